// File: rtl/audio_pkg.sv
// Sizes, address map, program word layout and bus types shared by the audio mixing RTL
package audio_pkg;

    // Input RAM geometry, 16 channels by 32 frames
    localparam int channels = 16;
    localparam int chan_w = $clog2(channels);
    localparam int frames = 32;
    localparam int frame_w = $clog2(frames);
    localparam int audio_words = channels * frames;
    localparam int audio_w = $clog2(audio_words);

    // Program store
    localparam int code_words = 256;
    localparam int code_w = $clog2(code_words);

    // Signed accumulator width
    localparam int acc_w = 40;

    // Window offsets from the peripheral base address
    localparam logic [31:0] off_coef = 32'h0000_0000;
    localparam logic [31:0] off_input = 32'h0000_0800;
    localparam logic [31:0] off_result = 32'h0000_1000;
    localparam logic [31:0] off_status = 32'h0000_1100;
    localparam logic [31:0] off_reset = 32'h0000_1200;

    typedef enum logic [1:0] {
        op_nop = 2'd0,
        op_mac = 2'd1,
        op_store = 2'd2,
        op_end = 2'd3
    } op_e;

    // Program word, opcode in the top two bits of every view
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            op_e op;
            logic [chan_w-1:0] chan;
            logic [frame_w-1:0] delay;
            logic [4:0] spare;
            logic signed [15:0] gain;
        } mac;
        struct packed {
            op_e op;
            // 0 selects left, 1 selects right
            logic side;
            logic [4:0] shift;
            logic [23:0] unused;
        } store;
    } seq_instr_u;

    // Host request on the memory port
    typedef struct packed {
        logic valid;
        logic [3:0] wstrb;
        logic [31:0] addr;
        logic [31:0] wdata;
    } iomem_req_s;

    // Result write from the sequencer
    typedef struct packed {
        logic we;
        logic side;
        logic [15:0] audio;
    } seq_out_s;

endpackage

// File: rtl/dpram.sv
// Simple dual-port RAM, one write port and one registered read port, used for program and samples
`timescale 1ns/100ps

module dpram #(
    parameter int bits = 32,
    parameter int size = 256
) (
    input  logic                    ck,
    input  logic                    we,
    input  logic [$clog2(size)-1:0] waddr,
    input  logic [bits-1:0]         wdata,
    input  logic [$clog2(size)-1:0] raddr,
    output logic [bits-1:0]         rdata
);

    // Contents survive a run restart
    logic [bits-1:0] mem [size];

    always_ff @(posedge ck) begin
        // Host side
        if (we) begin
            mem[waddr] <= wdata;
        end
        // Engine side, data one cycle after the address
        rdata <= mem[raddr];
    end

endmodule

// File: rtl/iomem_decode.sv
// Address window decoder for one register block, gives one-shot ready, write and read strobes
`timescale 1ns/100ps

module iomem_decode #(
    parameter logic [31:0] match_addr = 32'h0000_0000,
    parameter int window_bits = 10
) (
    input  logic                  ck,
    input  logic                  arst_n,
    input  audio_pkg::iomem_req_s req,
    output logic                  ready,
    output logic                  we,
    output logic                  re
);

    logic hit;
    logic seen;
    logic acked;
    logic fire;

    // Request falls inside this window
    assign hit = req.valid && (req.addr[31:window_bits] == match_addr[31:window_bits]);

    // Answer in the second cycle of a held request, once only
    assign fire = hit && seen && !acked && !ready;

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            seen <= 1'b0;
            acked <= 1'b0;
            ready <= 1'b0;
            we <= 1'b0;
            re <= 1'b0;
        end else begin
            seen <= hit;
            // Ready history, cleared when valid drops
            acked <= hit && (acked || ready);
            ready <= fire;
            // Any strobe bit set makes a full word write
            we <= fire && (req.wstrb != 4'h0);
            re <= fire && (req.wstrb == 4'h0);
        end
    end

endmodule

// File: rtl/mac_sequencer.sv
// Three stage program sequencer, fetch, sample read and accumulate, producing mixed audio results
`timescale 1ns/100ps

module mac_sequencer (
    input  logic                               ck,
    input  logic                               arst_n,
    input  logic                               run_rst,
    input  logic [audio_pkg::frame_w-1:0]      frame,
    input  audio_pkg::seq_instr_u              coef_rdata,
    input  logic [15:0]                        audio_rdata,
    output logic [audio_pkg::code_w-1:0]       coef_raddr,
    output logic [audio_pkg::audio_w-1:0]      audio_raddr,
    output audio_pkg::seq_out_s                out,
    output logic                               done,
    output logic                               error,
    output logic                               busy,
    output logic [31:0]                        capture
);

    localparam logic signed [audio_pkg::acc_w-1:0] sat_max = 32767;
    localparam logic signed [audio_pkg::acc_w-1:0] sat_min = -32768;

    // Fetch stage
    logic [audio_pkg::code_w-1:0] pc;
    logic fetching;
    logic issue;

    // Sample read stage, instruction word is on coef_rdata
    logic dec_v;
    logic dec_last;
    logic dec_flush;

    // Accumulate stage, sample is on audio_rdata
    logic exe_v;
    logic exe_last;
    audio_pkg::seq_instr_u exe_instr;

    logic signed [audio_pkg::acc_w-1:0] acc;
    logic signed [31:0] prod;
    logic signed [audio_pkg::acc_w-1:0] prod_ext;
    logic signed [audio_pkg::acc_w-1:0] shifted;
    logic [15:0] sat;

    // Store or end in the middle stage squashes the word fetched behind it
    assign dec_flush = dec_v && ((coef_rdata.mac.op == audio_pkg::op_store)
        || (coef_rdata.mac.op == audio_pkg::op_end));
    assign issue = fetching && !dec_flush;

    assign coef_raddr = pc;

    // Channel row, frame index wraps modulo 32
    assign audio_raddr = {coef_rdata.mac.chan, frame - coef_rdata.mac.delay};

    // Sample times gain, sign extended to the accumulator
    assign prod = $signed(audio_rdata) * $signed(exe_instr.mac.gain);
    assign prod_ext = prod;

    // Store path, arithmetic shift then clamp to 16 bits
    assign shifted = acc >>> exe_instr.store.shift;

    always_comb begin
        if (shifted > sat_max) begin
            sat = 16'h7fff;
        end else if (shifted < sat_min) begin
            sat = 16'h8000;
        end else begin
            sat = shifted[15:0];
        end
    end

    assign busy = fetching || dec_v || exe_v;

    // Instruction payload moves down without reset
    always_ff @(posedge ck) begin
        exe_instr <= coef_rdata;
    end

    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            pc <= '0;
            fetching <= 1'b0;
            dec_v <= 1'b0;
            dec_last <= 1'b0;
            exe_v <= 1'b0;
            exe_last <= 1'b0;
            acc <= '0;
            out <= '0;
            done <= 1'b0;
            error <= 1'b0;
            capture <= '0;
        end else if (run_rst) begin
            // Restart from the first program word
            pc <= '0;
            fetching <= 1'b1;
            dec_v <= 1'b0;
            dec_last <= 1'b0;
            exe_v <= 1'b0;
            exe_last <= 1'b0;
            acc <= '0;
            out.we <= 1'b0;
            done <= 1'b0;
            error <= 1'b0;
        end else begin
            // Fetch, last word stops the fetcher as the pc wraps
            if (issue) begin
                pc <= pc + 1'b1;
                if (&pc) begin
                    fetching <= 1'b0;
                end
            end
            if (dec_v && (coef_rdata.mac.op == audio_pkg::op_end)) begin
                fetching <= 1'b0;
            end
            dec_v <= issue;
            dec_last <= issue && (&pc);

            exe_v <= dec_v;
            exe_last <= dec_last;

            // Accumulate stage
            out.we <= 1'b0;
            if (exe_v) begin
                case (exe_instr.mac.op)
                    audio_pkg::op_mac: acc <= acc + prod_ext;
                    audio_pkg::op_store: begin
                        out.we <= 1'b1;
                        out.side <= exe_instr.store.side;
                        out.audio <= sat;
                        capture <= acc[31:0];
                        acc <= '0;
                    end
                    audio_pkg::op_end: done <= 1'b1;
                    default: ;
                endcase
                // Ran off the program end
                if (exe_last && (exe_instr.mac.op != audio_pkg::op_end)) begin
                    error <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/audio_engine.sv
// Audio mixing peripheral top, maps program, sample, result, status and reset windows onto the bus
`timescale 1ns/100ps

module audio_engine #(
    parameter logic [31:0] base_addr = 32'h0000_6000
) (
    input  logic                  ck,
    input  logic                  arst_n,
    input  audio_pkg::iomem_req_s req,
    output logic                  ready,
    output logic [31:0]           rdata
);

    // Address map
    localparam logic [31:0] coef_addr = base_addr + audio_pkg::off_coef;
    localparam logic [31:0] input_addr = base_addr + audio_pkg::off_input;
    localparam logic [31:0] result_addr = base_addr + audio_pkg::off_result;
    localparam logic [31:0] status_addr = base_addr + audio_pkg::off_status;
    localparam logic [31:0] reset_addr = base_addr + audio_pkg::off_reset;

    logic coef_ready, input_ready, result_ready, status_ready, reset_ready;
    logic coef_we, input_we, status_we, reset_we;
    logic result_re, status_re;

    // Request held by the host, sampled for the write cycle
    logic [audio_pkg::audio_w-1:0] word_q;
    logic [31:0] wdata_q;

    // Control register
    logic allow_audio_writes;
    logic [audio_pkg::frame_w-1:0] frame;

    // Run reset stretcher
    logic [1:0] run_cnt;
    logic run_rst;

    // Sequencer side
    audio_pkg::seq_instr_u coef_rdata;
    logic [audio_pkg::code_w-1:0] coef_raddr;
    logic [15:0] audio_rdata;
    logic [audio_pkg::audio_w-1:0] audio_raddr;
    audio_pkg::seq_out_s seq_out;
    logic done, error, busy;
    logic [31:0] capture;

    // Results and read data
    logic [15:0] left, right;
    logic [31:0] result_q, status_q;

    iomem_decode #(.match_addr(coef_addr), .window_bits(10)) coef_io (
        .ck(ck), .arst_n(arst_n), .req(req),
        .ready(coef_ready), .we(coef_we), .re());

    iomem_decode #(.match_addr(input_addr), .window_bits(11)) input_io (
        .ck(ck), .arst_n(arst_n), .req(req),
        .ready(input_ready), .we(input_we), .re());

    iomem_decode #(.match_addr(result_addr), .window_bits(3)) result_io (
        .ck(ck), .arst_n(arst_n), .req(req),
        .ready(result_ready), .we(), .re(result_re));

    iomem_decode #(.match_addr(status_addr), .window_bits(3)) status_io (
        .ck(ck), .arst_n(arst_n), .req(req),
        .ready(status_ready), .we(status_we), .re(status_re));

    iomem_decode #(.match_addr(reset_addr), .window_bits(2)) reset_io (
        .ck(ck), .arst_n(arst_n), .req(req),
        .ready(reset_ready), .we(reset_we), .re());

    always_ff @(posedge ck) begin
        word_q <= req.addr[2 +: audio_pkg::audio_w];
        wdata_q <= req.wdata;
    end

    // Program RAM, host writes, sequencer reads
    dpram #(.bits(32), .size(audio_pkg::code_words)) coef_ram (
        .ck(ck), .we(coef_we), .waddr(word_q[audio_pkg::code_w-1:0]), .wdata(wdata_q),
        .raddr(coef_raddr), .rdata(coef_rdata));

    // Sample RAM, writes dropped while protected
    dpram #(.bits(16), .size(audio_pkg::audio_words)) audio_ram (
        .ck(ck), .we(input_we && allow_audio_writes), .waddr(word_q),
        .wdata(wdata_q[15:0]), .raddr(audio_raddr), .rdata(audio_rdata));

    // Bit 0 unlocks sample writes, bits 5:1 select the frame
    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            allow_audio_writes <= 1'b0;
            frame <= '0;
        end else if (status_we) begin
            allow_audio_writes <= wdata_q[0];
            frame <= wdata_q[5:1];
        end
    end

    // Three cycles of run reset after power up or a reset write
    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            run_cnt <= 2'd0;
        end else if (reset_we) begin
            run_cnt <= 2'd0;
        end else if (run_cnt != 2'd3) begin
            run_cnt <= run_cnt + 2'd1;
        end
    end

    assign run_rst = (run_cnt != 2'd3);

    mac_sequencer seq (
        .ck(ck), .arst_n(arst_n), .run_rst(run_rst), .frame(frame),
        .coef_rdata(coef_rdata), .audio_rdata(audio_rdata),
        .coef_raddr(coef_raddr), .audio_raddr(audio_raddr), .out(seq_out),
        .done(done), .error(error), .busy(busy), .capture(capture));

    // Result registers
    always_ff @(posedge ck or negedge arst_n) begin
        if (!arst_n) begin
            left <= '0;
            right <= '0;
        end else if (seq_out.we) begin
            if (seq_out.side) begin
                right <= seq_out.audio;
            end else begin
                left <= seq_out.audio;
            end
        end
    end

    // Read words loaded while the request is held, shown in the ready cycle
    always_ff @(posedge ck) begin
        result_q <= {16'h0, req.addr[2] ? right : left};
        status_q <= req.addr[2] ? capture : {29'h0, busy, error, done};
    end

    assign rdata = (result_re ? result_q : 32'h0) | (status_re ? status_q : 32'h0);
    assign ready = coef_ready | input_ready | result_ready | status_ready | reset_ready;

endmodule

// File: verification/clock_gen.sv
// Testbench clock of 8 ns period with an active low reset released after four cycles
`timescale 1ns/100ps

module clock_gen (
    output logic ck,
    output logic arst_n
);

    initial begin
        ck = 1'b0;
        forever #4 ck = ~ck;
    end

    // Four rising edges under reset, release on the following falling edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge ck);
        @(negedge ck);
        arst_n = 1'b1;
    end

endmodule

// File: verification/tb_audio_engine.sv
// Testbench for the audio engine that checks random programs and samples against a reference model
`timescale 1ns/100ps

module tb_audio_engine;

    // Default base address of the DUT and its windows
    localparam logic [31:0] coef_base = 32'h0000_6000;
    localparam logic [31:0] input_base = 32'h0000_6800;
    localparam logic [31:0] result_addr = 32'h0000_7000;
    localparam logic [31:0] status_addr = 32'h0000_7100;
    localparam logic [31:0] reset_addr = 32'h0000_7200;
    localparam int cycle_limit = 20000;

    logic ck;
    logic arst_n;
    audio_pkg::iomem_req_s req;
    logic ready;
    logic [31:0] rdata;

    int cycles = 0;
    int checks = 0;
    int errors = 0;

    // Reference program image, sample image and expected results
    logic [31:0] prog [256];
    logic [15:0] smp [512];
    logic [15:0] exp_left;
    logic [15:0] exp_right;
    logic [31:0] exp_capture;
    logic exp_done;
    logic exp_error;
    logic allow;
    logic [4:0] cur_frame;
    logic [31:0] first_status;

    clock_gen clocks (.ck(ck), .arst_n(arst_n));

    audio_engine dut (.ck(ck), .arst_n(arst_n), .req(req), .ready(ready), .rdata(rdata));

    // Run limit
    always @(posedge ck) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Starts and ends on a falling edge and leaves valid low for one cycle
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        int waited;
        req.valid = 1'b1;
        req.wstrb = 4'($urandom_range(1, 15));
        req.addr = addr;
        req.wdata = data;
        waited = 1;
        @(negedge ck);
        while (!ready) begin
            @(negedge ck);
            waited++;
        end
        // Mapped accesses answer two cycles after valid
        compare($sformatf("write latency %h", addr), 32'd2, 32'(waited));
        req.valid = 1'b0;
        req.wstrb = 4'h0;
        @(negedge ck);
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
        int waited;
        req.valid = 1'b1;
        req.wstrb = 4'h0;
        req.addr = addr;
        waited = 1;
        @(negedge ck);
        while (!ready) begin
            @(negedge ck);
            waited++;
        end
        compare($sformatf("read latency %h", addr), 32'd2, 32'(waited));
        data = rdata;
        req.valid = 1'b0;
        @(negedge ck);
    endtask

    function automatic logic [31:0] mac_word(int chan, int delay, logic [15:0] gain);
        return {2'd1, 4'(chan), 5'(delay), 5'd0, gain};
    endfunction

    function automatic logic [31:0] store_word(int side, int shift);
        return {2'd2, 1'(side), 5'(shift), 24'd0};
    endfunction

    // Sample writes only land in the image while unprotected
    task automatic write_sample(input int idx, input logic [15:0] value);
        bus_write(input_base + 32'(idx) * 4, {16'($urandom), value});
        if (allow) smp[idx] = value;
    endtask

    task automatic write_program(input int n);
        for (int i = 0; i < n; i++) bus_write(coef_base + 32'(i) * 4, prog[i]);
    endtask

    task automatic set_control(input logic en, input int fr);
        bus_write(status_addr, {26'h0, 5'(fr), en});
        allow = en;
        cur_frame = 5'(fr);
    endtask

    // Random mix of MAC, nop and store words with an optional op_end after them
    task automatic random_program(input int n, input bit with_end);
        int r;
        for (int i = 0; i < n; i++) begin
            r = $urandom_range(0, 9);
            if (r < 6) prog[i] = mac_word($urandom_range(0, 15), $urandom_range(0, 31),
                16'($urandom));
            else if (r < 8) prog[i] = {2'd0, 30'($urandom)};
            else prog[i] = store_word($urandom_range(0, 1), $urandom_range(0, 24));
        end
        if (with_end) prog[n] = {2'd3, 30'd0};
    endtask

    // Sequential walk of the program where results persist between runs
    task automatic run_model();
        longint acc;
        longint s;
        longint g;
        longint shifted;
        logic [31:0] w;
        logic [4:0] fi;
        logic [15:0] val;
        acc = 0;
        exp_done = 1'b0;
        exp_error = 1'b1;
        for (int i = 0; i < 256; i++) begin
            w = prog[i];
            if (w[31:30] == 2'd3) begin
                exp_done = 1'b1;
                exp_error = 1'b0;
                break;
            end
            if (w[31:30] == 2'd1) begin
                // Frame index wraps modulo 32
                fi = cur_frame - w[25:21];
                s = $signed(smp[{w[29:26], fi}]);
                g = $signed(w[15:0]);
                acc = acc + s * g;
            end else if (w[31:30] == 2'd2) begin
                shifted = acc >>> w[28:24];
                if (shifted > 32767) val = 16'h7fff;
                else if (shifted < -32768) val = 16'h8000;
                else val = shifted[15:0];
                if (w[29]) exp_right = val;
                else exp_left = val;
                exp_capture = acc[31:0];
                acc = 0;
            end
        end
    endtask

    // Restart through the reset register and poll status until the run ends
    task automatic run_and_check(input string name);
        logic [31:0] st;
        logic [31:0] val;
        run_model();
        bus_write(reset_addr, $urandom);
        bus_read(status_addr, st);
        first_status = st;
        while (!(st[0] || st[1])) bus_read(status_addr, st);
        compare({name, " status"}, {29'h0, 1'b0, exp_error, exp_done}, st);
        bus_read(result_addr, val);
        compare({name, " left"}, {16'h0, exp_left}, val);
        bus_read(result_addr + 4, val);
        compare({name, " right"}, {16'h0, exp_right}, val);
        bus_read(status_addr + 4, val);
        compare({name, " capture"}, exp_capture, val);
    endtask

    initial begin
        logic [31:0] st;
        int ch;
        int fr;
        int n;
        void'($urandom(32'h330a));
        req = '0;
        allow = 1'b0;
        cur_frame = '0;
        exp_left = '0;
        exp_right = '0;
        exp_capture = '0;
        @(posedge arst_n);
        @(negedge ck);

        // Reset state and then a program of op_end alone
        bus_read(status_addr, st);
        compare("reset status", 32'h0, {30'h0, st[1:0]});
        bus_read(result_addr, st);
        compare("reset left", 32'h0, st);
        bus_read(result_addr + 4, st);
        compare("reset right", 32'h0, st);
        prog[0] = {2'd3, 30'd0};
        write_program(1);
        run_and_check("empty program");

        // Fill every sample with a value scrambled from the whole index
        set_control(1'b1, 0);
        for (int i = 0; i < 512; i++) write_sample(i, 16'(i * 32'h9e37) ^ 16'h5a5a);

        // Protected writes must not reach the samples read by the program
        ch = $urandom_range(0, 15);
        fr = $urandom_range(0, 31);
        set_control(1'b1, fr);
        write_sample(ch * 32 + fr, 16'h0);
        write_sample(ch * 32 + (fr + 31) % 32, 16'h0);
        set_control(1'b0, fr);
        write_sample(ch * 32 + fr, 16'($urandom_range(1, 65535)));
        write_sample(ch * 32 + (fr + 31) % 32, 16'($urandom_range(1, 65535)));
        // Nonzero gains so a leaked sample shows up in the result
        prog[0] = mac_word(ch, 0, 16'($urandom_range(1, 65535)));
        prog[1] = store_word(0, 0);
        prog[2] = mac_word(ch, 1, 16'($urandom_range(1, 65535)));
        prog[3] = store_word(1, 0);
        prog[4] = {2'd3, 30'd0};
        write_program(5);
        run_and_check("write protect");

        for (int round = 0; round < 50; round++) begin
            set_control(1'b1, $urandom_range(0, 31));
            repeat (4) write_sample($urandom_range(0, 511), 16'($urandom));
            n = $urandom_range(1, 40);
            random_program(n, 1'b1);
            write_program(n + 1);
            run_and_check($sformatf("random round %0d", round));
        end

        // Full scale products on both sides
        set_control(1'b1, 3);
        write_sample(2 * 32 + 3, 16'h7fff);
        write_sample(5 * 32 + 3, 16'h8000);
        prog[0] = mac_word(2, 0, 16'h7fff);
        prog[1] = mac_word(2, 0, 16'h7fff);
        prog[2] = store_word(0, 0);
        prog[3] = mac_word(5, 0, 16'h7fff);
        prog[4] = store_word(1, 0);
        prog[5] = {2'd3, 30'd0};
        write_program(6);
        run_and_check("saturation");

        // Whole program store without op_end
        random_program(256, 1'b0);
        write_program(256);
        run_and_check("no end");

        // Same program twice with the frame changed in between
        random_program(20, 1'b1);
        write_program(21);
        set_control(1'b1, 7);
        run_and_check("restart first");
        set_control(1'b1, 8);
        run_and_check("restart second");
        compare("restart clears done", 32'h0, {31'h0, first_status[0]});

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
rtl/audio_pkg.sv
rtl/dpram.sv
rtl/iomem_decode.sv
rtl/mac_sequencer.sv
rtl/audio_engine.sv
verification/clock_gen.sv
verification/tb_audio_engine.sv

// File: run_sim.sh
#!/bin/sh
# Build the audio engine testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f compile.f \
    --top-module tb_audio_engine \
    -Mdir obj_dir

./obj_dir/Vtb_audio_engine > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation finished without reported failures"
